// ==== source/sigencode_z_pkg.sv ====
/*
 * Shared constants for the z-part signature encoder.
 * Holds the modulus, the polynomial geometry and the default widths that
 * the RTL parameters and the testbench model start from.
 */

package sigencode_z_pkg;

    // ==================================================
    // Scheme constants
    // ==================================================

    // Prime modulus of the coefficient ring
    localparam logic [22:0] dilithium_q = 23'd8380417;

    // Largest coefficient that still centers to a non-negative value
    localparam logic [22:0] dilithium_q_half = (dilithium_q - 23'd1) >> 1;

    // Coefficients in one polynomial
    localparam int dilithium_n = 256;

    // Number of z polynomials in a full signature
    localparam int dilithium_l_default = 7;

    // ==================================================
    // Storage geometry and default widths
    // ==================================================

    // Coefficients packed side by side in one buffer word
    localparam int coeffs_per_word = 4;

    // Stored width of one coefficient
    localparam int reg_size_default = 24;

    // Encoding exponent, each encoded value is gamma1 + 1 bits wide
    localparam int gamma1_default = 19;

    // Word address width, enough for 7 polynomials of 64 words
    localparam int mem_addr_width_default = 10;

endpackage

// ==== source/coeff_mem.sv ====
/*
 * Coefficient buffer feeding the encoder lanes.
 * One load port fills it while the controller is idle. Two read ports
 * return a word pair one cycle after rd_en, four coefficients per word.
 */

`timescale 1ns/1ns

module coeff_mem
    import sigencode_z_pkg::*;
#(
    parameter int MEM_ADDR_WIDTH = mem_addr_width_default,
    parameter int REG_SIZE = reg_size_default
) (
    input  logic                                        clk,

    // Load port
    input  logic                                        load_en,
    input  logic [MEM_ADDR_WIDTH-1:0]                   load_addr,
    input  logic [coeffs_per_word-1:0][REG_SIZE-1:0]    load_data,

    // Paired read ports
    input  logic                                        rd_en,
    input  logic [MEM_ADDR_WIDTH-1:0]                   rd_addr_a,
    input  logic [MEM_ADDR_WIDTH-1:0]                   rd_addr_b,
    output logic [coeffs_per_word-1:0][REG_SIZE-1:0]    rd_data_a,
    output logic [coeffs_per_word-1:0][REG_SIZE-1:0]    rd_data_b
);

    localparam int depth = 2 ** MEM_ADDR_WIDTH;

    // Word storage, one packed group of coefficients per entry
    logic [coeffs_per_word-1:0][REG_SIZE-1:0] mem [depth];

    // ==================================================
    // Write port
    // ==================================================

    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
    end

    // ==================================================
    // Read ports
    // ==================================================

    // Output registers hold their last word while no read is requested
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data_a <= mem[rd_addr_a];
            rd_data_b <= mem[rd_addr_b];
        end
    end

endmodule

// ==== source/sigencode_z_ctrl.sv ====
/*
 * Run controller for the z encoder.
 * Locks the base addresses on enable, walks the buffer one word pair per
 * cycle, issues the matching write pairs two cycles later and ends the
 * run with a single-cycle done pulse.
 */

`timescale 1ns/1ns

module sigencode_z_ctrl
    import sigencode_z_pkg::*;
#(
    parameter int MEM_ADDR_WIDTH = mem_addr_width_default,
    parameter int NUM_POLYS = dilithium_l_default
) (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        zeroize,

    // Run control
    input  logic                        enable,
    input  logic [MEM_ADDR_WIDTH-1:0]   src_base_addr,
    input  logic [MEM_ADDR_WIDTH-1:0]   dest_base_addr,

    // Buffer read requests
    output logic                        rd_en,
    output logic [MEM_ADDR_WIDTH-1:0]   rd_addr_a,
    output logic [MEM_ADDR_WIDTH-1:0]   rd_addr_b,

    // Signature memory write requests
    output logic                        sig_a_wr_en,
    output logic [MEM_ADDR_WIDTH-1:0]   sig_a_wr_addr,
    output logic                        sig_b_wr_en,
    output logic [MEM_ADDR_WIDTH-1:0]   sig_b_wr_addr,

    output logic                        done
);

    // Words covered by one run, always even
    localparam int words_per_run = (NUM_POLYS * dilithium_n) / coeffs_per_word;

    // Offset of the final read pair
    localparam logic [MEM_ADDR_WIDTH-1:0] last_pair = MEM_ADDR_WIDTH'(words_per_run - 2);

    localparam logic [MEM_ADDR_WIDTH-1:0] pair_step = MEM_ADDR_WIDTH'(2);

    // FSM encoding
    localparam logic [2:0] st_idle        = 3'd0;
    localparam logic [2:0] st_read        = 3'd1;
    localparam logic [2:0] st_read_enc    = 3'd2;
    localparam logic [2:0] st_read_enc_wr = 3'd3;
    localparam logic [2:0] st_enc_wr      = 3'd4;
    localparam logic [2:0] st_wr          = 3'd5;
    localparam logic [2:0] st_finish      = 3'd6;

    logic [2:0]                 state;
    logic [2:0]                 next_state;
    logic [MEM_ADDR_WIDTH-1:0]  rd_cnt;
    logic [MEM_ADDR_WIDTH-1:0]  wr_cnt;
    logic [MEM_ADDR_WIDTH-1:0]  locked_src;
    logic [MEM_ADDR_WIDTH-1:0]  locked_dest;
    logic                       finish_hold;
    logic                       reading;
    logic                       writing;

    // A read pair is issued at the end of every read state, likewise for writes
    assign reading = (state == st_read) || (state == st_read_enc) ||
                     (state == st_read_enc_wr);
    assign writing = (state == st_read_enc_wr) || (state == st_enc_wr) ||
                     (state == st_wr);

    // ==================================================
    // State machine
    // ==================================================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= st_idle;
        end else if (zeroize) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (enable) begin
                    next_state = st_read;
                end
            end
            st_read:     next_state = st_read_enc;
            st_read_enc: next_state = st_read_enc_wr;
            st_read_enc_wr: begin
                // Stay here until the final pair has gone out
                if (rd_cnt == last_pair) begin
                    next_state = st_enc_wr;
                end
            end
            st_enc_wr:   next_state = st_wr;
            st_wr:       next_state = st_finish;
            st_finish: begin
                // Finish lasts two cycles so done lines up with the return to idle
                if (finish_hold) begin
                    next_state = st_idle;
                end
            end
            default:     next_state = st_idle;
        endcase
    end

    // ==================================================
    // Base addresses and pair counters
    // ==================================================

    // Bases are taken only on the enable edge that starts a run
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            locked_src  <= '0;
            locked_dest <= '0;
        end else if (zeroize) begin
            locked_src  <= '0;
            locked_dest <= '0;
        end else if (state == st_idle && enable) begin
            locked_src  <= src_base_addr;
            locked_dest <= dest_base_addr;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_cnt <= '0;
            wr_cnt <= '0;
        end else if (zeroize) begin
            rd_cnt <= '0;
            wr_cnt <= '0;
        end else begin
            rd_cnt <= reading ? rd_cnt + pair_step : '0;
            wr_cnt <= writing ? wr_cnt + pair_step : '0;
        end
    end

    // ==================================================
    // Request outputs
    // ==================================================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_en     <= 1'b0;
            rd_addr_a <= '0;
            rd_addr_b <= '0;
        end else if (zeroize || !reading) begin
            rd_en     <= 1'b0;
            rd_addr_a <= '0;
            rd_addr_b <= '0;
        end else begin
            rd_en     <= 1'b1;
            rd_addr_a <= locked_src + rd_cnt;
            rd_addr_b <= locked_src + rd_cnt + 1'b1;
        end
    end

    // Writes trail reads by two cycles, one for the buffer and one for the lanes
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            sig_a_wr_en   <= 1'b0;
            sig_b_wr_en   <= 1'b0;
            sig_a_wr_addr <= '0;
            sig_b_wr_addr <= '0;
        end else if (zeroize || !writing) begin
            sig_a_wr_en   <= 1'b0;
            sig_b_wr_en   <= 1'b0;
            sig_a_wr_addr <= '0;
            sig_b_wr_addr <= '0;
        end else begin
            sig_a_wr_en   <= 1'b1;
            sig_b_wr_en   <= 1'b1;
            sig_a_wr_addr <= locked_dest + wr_cnt;
            sig_b_wr_addr <= locked_dest + wr_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            finish_hold <= 1'b0;
            done        <= 1'b0;
        end else if (zeroize) begin
            finish_hold <= 1'b0;
            done        <= 1'b0;
        end else begin
            finish_hold <= (state == st_finish) && !finish_hold;
            done        <= (state == st_finish) && finish_hold;
        end
    end

endmodule

// ==== source/sigencode_z_encoder.sv ====
/*
 * Four-lane z encoder with one register stage.
 * Each lane centers its coefficient modulo q and subtracts the result
 * from two to the power GAMMA1, keeping GAMMA1 + 1 bits.
 */

`timescale 1ns/1ns

module sigencode_z_encoder
    import sigencode_z_pkg::*;
#(
    parameter int REG_SIZE = reg_size_default,
    parameter int GAMMA1 = gamma1_default
) (
    input  logic                                        clk,
    input  logic                                        reset_n,
    input  logic                                        zeroize,
    input  logic [coeffs_per_word-1:0][REG_SIZE-1:0]    data_in,
    output logic [coeffs_per_word-1:0][GAMMA1:0]        data_out
);

    // Working width, wide enough for q, the coefficient and 2^GAMMA1
    localparam int calc_w = ((REG_SIZE > GAMMA1) ? REG_SIZE : GAMMA1) + 2;

    localparam logic [calc_w-1:0] q_ext     = calc_w'(dilithium_q);
    localparam logic [calc_w-1:0] half_ext  = calc_w'(dilithium_q_half);
    localparam logic [calc_w-1:0] gamma_ext = calc_w'(1) << GAMMA1;

    logic [coeffs_per_word-1:0][GAMMA1:0] enc_next;

    // ==================================================
    // Centering and subtraction
    // ==================================================

    // Upper half coefficients stand for c - q, so 2^GAMMA1 - (c - q) adds q back.
    // Truncation to GAMMA1 + 1 bits makes the wrap of the difference harmless
    always_comb begin
        logic [calc_w-1:0] c_ext;
        logic [calc_w-1:0] diff;
        for (int i = 0; i < coeffs_per_word; i++) begin
            c_ext = calc_w'(data_in[i]);
            diff  = gamma_ext - c_ext;
            if (c_ext > half_ext) begin
                diff = diff + q_ext;
            end
            enc_next[i] = diff[GAMMA1:0];
        end
    end

    // ==================================================
    // Output register
    // ==================================================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            data_out <= '0;
        end else if (zeroize) begin
            data_out <= '0;
        end else begin
            data_out <= enc_next;
        end
    end

endmodule

// ==== source/sigencode_z_top.sv ====
/*
 * Top level of the z-part signature encoder.
 * Joins the coefficient buffer, the run controller and two encoder lanes,
 * and drives two write ports toward the external signature memory.
 */

`timescale 1ns/1ns

module sigencode_z_top
    import sigencode_z_pkg::*;
#(
    parameter int MEM_ADDR_WIDTH = mem_addr_width_default,
    parameter int REG_SIZE = reg_size_default,
    parameter int GAMMA1 = gamma1_default,
    parameter int NUM_POLYS = dilithium_l_default
) (
    input  logic                                        clk,
    input  logic                                        reset_n,
    input  logic                                        zeroize,

    // Buffer load port, used only while idle
    input  logic                                        load_en,
    input  logic [MEM_ADDR_WIDTH-1:0]                   load_addr,
    input  logic [coeffs_per_word-1:0][REG_SIZE-1:0]    load_data,

    // Run control
    input  logic [MEM_ADDR_WIDTH-1:0]                   src_base_addr,
    input  logic [MEM_ADDR_WIDTH-1:0]                   dest_base_addr,
    input  logic                                        enable,

    // Signature memory write ports
    output logic                                        sig_a_wr_en,
    output logic [MEM_ADDR_WIDTH-1:0]                   sig_a_wr_addr,
    output logic [coeffs_per_word-1:0][GAMMA1:0]        sig_a_wr_data,
    output logic                                        sig_b_wr_en,
    output logic [MEM_ADDR_WIDTH-1:0]                   sig_b_wr_addr,
    output logic [coeffs_per_word-1:0][GAMMA1:0]        sig_b_wr_data,

    output logic                                        done
);

    logic                                       rd_en;
    logic [MEM_ADDR_WIDTH-1:0]                  rd_addr_a;
    logic [MEM_ADDR_WIDTH-1:0]                  rd_addr_b;
    logic [coeffs_per_word-1:0][REG_SIZE-1:0]   rd_data_a;
    logic [coeffs_per_word-1:0][REG_SIZE-1:0]   rd_data_b;

    // ==================================================
    // Buffer and controller
    // ==================================================

    coeff_mem #(
        .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH),
        .REG_SIZE       (REG_SIZE)
    ) u_mem (
        .clk        (clk),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .rd_en      (rd_en),
        .rd_addr_a  (rd_addr_a),
        .rd_addr_b  (rd_addr_b),
        .rd_data_a  (rd_data_a),
        .rd_data_b  (rd_data_b)
    );

    sigencode_z_ctrl #(
        .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH),
        .NUM_POLYS      (NUM_POLYS)
    ) u_ctrl (
        .clk            (clk),
        .reset_n        (reset_n),
        .zeroize        (zeroize),
        .enable         (enable),
        .src_base_addr  (src_base_addr),
        .dest_base_addr (dest_base_addr),
        .rd_en          (rd_en),
        .rd_addr_a      (rd_addr_a),
        .rd_addr_b      (rd_addr_b),
        .sig_a_wr_en    (sig_a_wr_en),
        .sig_a_wr_addr  (sig_a_wr_addr),
        .sig_b_wr_en    (sig_b_wr_en),
        .sig_b_wr_addr  (sig_b_wr_addr),
        .done           (done)
    );

    // ==================================================
    // Encoder lanes
    // ==================================================

    // Lane outputs land in step with the controller's write addresses
    sigencode_z_encoder #(
        .REG_SIZE   (REG_SIZE),
        .GAMMA1     (GAMMA1)
    ) lane_a (
        .clk        (clk),
        .reset_n    (reset_n),
        .zeroize    (zeroize),
        .data_in    (rd_data_a),
        .data_out   (sig_a_wr_data)
    );

    sigencode_z_encoder #(
        .REG_SIZE   (REG_SIZE),
        .GAMMA1     (GAMMA1)
    ) lane_b (
        .clk        (clk),
        .reset_n    (reset_n),
        .zeroize    (zeroize),
        .data_in    (rd_data_b),
        .data_out   (sig_b_wr_data)
    );

endmodule

// ==== verif/sigencode_z_tb.sv ====
/*
 * Self-checking testbench for the z-part signature encoder.
 * Reads corner coefficients and run configurations from the trace file,
 * loads the buffer, runs encodes and checks every write port cycle by cycle.
 */

`timescale 1ns/1ns

module sigencode_z_tb
    import sigencode_z_pkg::*;
();

    localparam int addr_w = 10;
    localparam int num_polys = 1;
    localparam int reg_size = reg_size_default;
    localparam int gamma1 = gamma1_default;
    localparam int words = (num_polys * dilithium_n) / coeffs_per_word;
    localparam int pairs = words / 2;
    localparam int trace_words = 46;

    logic                                       clk;
    logic                                       reset_n;
    logic                                       zeroize;
    logic                                       load_en;
    logic [addr_w-1:0]                          load_addr;
    logic [coeffs_per_word-1:0][reg_size-1:0]   load_data;
    logic [addr_w-1:0]                          src_base_addr;
    logic [addr_w-1:0]                          dest_base_addr;
    logic                                       enable;
    logic                                       sig_a_wr_en;
    logic [addr_w-1:0]                          sig_a_wr_addr;
    logic [coeffs_per_word-1:0][gamma1:0]       sig_a_wr_data;
    logic                                       sig_b_wr_en;
    logic [addr_w-1:0]                          sig_b_wr_addr;
    logic [coeffs_per_word-1:0][gamma1:0]       sig_b_wr_data;
    logic                                       done;

    logic [31:0]        trace_mem [trace_words];
    // Expected encoding of every buffer word as it is filled in while loading
    logic [gamma1:0]    exp_mem [2**addr_w][coeffs_per_word];
    integer             seed;
    int                 num_corners;
    int                 num_runs;
    logic               trace_ready;

    sigencode_z_top #(
        .MEM_ADDR_WIDTH (addr_w),
        .REG_SIZE       (reg_size),
        .GAMMA1         (gamma1),
        .NUM_POLYS      (num_polys)
    ) u_dut (
        .clk            (clk),
        .reset_n        (reset_n),
        .zeroize        (zeroize),
        .load_en        (load_en),
        .load_addr      (load_addr),
        .load_data      (load_data),
        .src_base_addr  (src_base_addr),
        .dest_base_addr (dest_base_addr),
        .enable         (enable),
        .sig_a_wr_en    (sig_a_wr_en),
        .sig_a_wr_addr  (sig_a_wr_addr),
        .sig_a_wr_data  (sig_a_wr_data),
        .sig_b_wr_en    (sig_b_wr_en),
        .sig_b_wr_addr  (sig_b_wr_addr),
        .sig_b_wr_data  (sig_b_wr_data),
        .done           (done)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // ==================================================
    // Reference model and checking
    // ==================================================

    // Center c modulo q, then take 2^gamma1 - v on gamma1 + 1 bits
    function automatic logic [gamma1:0] encode_coeff(input logic [reg_size-1:0] c);
        longint v;
        longint r;
        if (longint'(c) <= (longint'(dilithium_q) - 1) / 2) begin
            v = longint'(c);
        end else begin
            v = longint'(c) - longint'(dilithium_q);
        end
        r = (longint'(1) <<< gamma1) - v;
        return r[gamma1:0];
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s expected 0x%0h actual 0x%0h", name, expected, actual);
            $display("Checks failed");
            $fatal(1, "Stopping at the first error");
        end
    endtask

    task automatic check_word(input string tag, input logic [addr_w-1:0] src_addr,
                              input logic [coeffs_per_word-1:0][gamma1:0] data);
        for (int i = 0; i < coeffs_per_word; i++) begin
            check_value($sformatf("%s lane%0d", tag, i), exp_mem[src_addr][i], data[i]);
        end
    endtask

    // ==================================================
    // Stimulus
    // ==================================================

    // Fill 0 repeats the trace corners and any other fill draws random coefficients
    task automatic load_buffer(input int fill, input logic [addr_w-1:0] src);
        logic [coeffs_per_word-1:0][reg_size-1:0] word;
        logic [reg_size-1:0] c;
        logic [addr_w-1:0] addr;
        int j;
        for (int w = 0; w < words; w++) begin
            addr = addr_w'(src + w);
            for (int i = 0; i < coeffs_per_word; i++) begin
                j = (w * coeffs_per_word + i) % num_corners;
                if (fill == 0) begin
                    c = trace_mem[1 + 2 * j][reg_size-1:0];
                    exp_mem[addr][i] = trace_mem[2 + 2 * j][gamma1:0];
                end else begin
                    c = reg_size'($unsigned($random(seed)) % dilithium_q);
                    exp_mem[addr][i] = encode_coeff(c);
                end
                word[i] = c;
            end
            @(posedge clk);
            load_en   <= 1'b1;
            load_addr <= addr;
            load_data <= word;
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    // Cycle numbers count rising edges after the edge that samples enable
    task automatic run_encode(input int run, input int zc, input logic [addr_w-1:0] src,
                              input logic [addr_w-1:0] dest);
        int hold;
        int k;
        bit stopped;
        bit exp_wr;
        bit exp_done;
        string tag;
        // A full run keeps enable high up to the done cycle, so any restart would show
        hold = (zc != 0) ? 1 : pairs + 4;
        @(posedge clk);
        src_base_addr  <= src;
        dest_base_addr <= dest;
        enable         <= 1'b1;
        for (int cyc = 0; cyc <= pairs + 10; cyc++) begin
            @(posedge clk);
            if (cyc == 0) begin
                src_base_addr  <= addr_w'($random(seed));
                dest_base_addr <= addr_w'($random(seed));
            end
            enable  <= (cyc < hold);
            zeroize <= (zc != 0) && (cyc == zc - 1);
            @(negedge clk);
            stopped  = (zc != 0) && (cyc >= zc);
            exp_wr   = !stopped && (cyc >= 3) && (cyc <= pairs + 2);
            exp_done = !stopped && (cyc == pairs + 4);
            tag = $sformatf("run%0d cycle%0d", run, cyc);
            check_value($sformatf("%s a_wr_en", tag), exp_wr, sig_a_wr_en);
            check_value($sformatf("%s b_wr_en", tag), exp_wr, sig_b_wr_en);
            check_value($sformatf("%s done", tag), exp_done, done);
            if (exp_wr) begin
                k = cyc - 3;
                check_value($sformatf("%s a_addr", tag), addr_w'(dest + 2 * k), sig_a_wr_addr);
                check_value($sformatf("%s b_addr", tag), addr_w'(dest + 2 * k + 1),
                            sig_b_wr_addr);
                check_word($sformatf("%s a_data", tag), addr_w'(src + 2 * k), sig_a_wr_data);
                check_word($sformatf("%s b_data", tag), addr_w'(src + 2 * k + 1), sig_b_wr_data);
            end
            // Zeroize clears the lanes and the write addresses as well
            if (zc != 0 && cyc == zc) begin
                check_value($sformatf("%s a_addr clear", tag), 0, sig_a_wr_addr);
                check_value($sformatf("%s b_addr clear", tag), 0, sig_b_wr_addr);
                for (int i = 0; i < coeffs_per_word; i++) begin
                    check_value($sformatf("%s a_data clear %0d", tag, i), 0, sig_a_wr_data[i]);
                    check_value($sformatf("%s b_data clear %0d", tag, i), 0, sig_b_wr_data[i]);
                end
            end
        end
    endtask

    // ==================================================
    // Main sequence and watchdog
    // ==================================================

    initial begin
        int base;
        seed           = 32'he041;
        trace_ready    = 1'b0;
        reset_n        = 1'b0;
        zeroize        = 1'b0;
        load_en        = 1'b0;
        load_addr      = '0;
        load_data      = '0;
        src_base_addr  = '0;
        dest_base_addr = '0;
        enable         = 1'b0;
        $readmemh("verif/sigencode_z_trace.txt", trace_mem);
        num_corners = trace_mem[0];
        num_runs    = trace_mem[1 + 2 * num_corners];
        trace_ready = 1'b1;
        // The model has to agree with the hand-worked corner codes
        for (int j = 0; j < num_corners; j++) begin
            check_value($sformatf("corner%0d model", j), trace_mem[2 + 2 * j][gamma1:0],
                        encode_coeff(trace_mem[1 + 2 * j][reg_size-1:0]));
        end
        repeat (16) @(posedge clk);
        reset_n <= 1'b1;
        repeat (4) begin
            @(negedge clk);
            check_value("after reset a_wr_en", 0, sig_a_wr_en);
            check_value("after reset b_wr_en", 0, sig_b_wr_en);
            check_value("after reset done", 0, done);
            check_value("after reset a_addr", 0, sig_a_wr_addr);
            check_value("after reset b_addr", 0, sig_b_wr_addr);
        end
        for (int r = 0; r < num_runs; r++) begin
            base = 2 + 2 * num_corners + 4 * r;
            load_buffer(trace_mem[base], trace_mem[base + 1][addr_w-1:0]);
            run_encode(r, trace_mem[base + 3], trace_mem[base + 1][addr_w-1:0],
                       trace_mem[base + 2][addr_w-1:0]);
        end
        $display("All checks passed");
        $finish;
    end

    initial begin
        int limit;
        wait (trace_ready);
        limit = num_runs * (pairs + 20) + num_runs * (words + 4) + 16 + 50;
        repeat (limit) @(posedge clk);
        $display("Timeout: the encode runs did not complete within %0d cycles", limit);
        $display("Checks failed");
        $fatal(1, "Watchdog expired");
    end

endmodule

// ==== verif/sigencode_z_trace.txt ====
// Corners: the count, then one coefficient and its expected code per line (GAMMA1 = 19)
// Runs: the count, then fill (0 corners, 1 random), src base, dest base, zeroize cycle
0000000C
000000 80000   // zero
000001 7FFFF
000002 7FFFE
3FF000 81000   // (q-1)/2
3FF001 7F000   // (q+1)/2
7FE000 80001   // q-1
080000 00000   // v = +2^19
77E001 00000   // v = -2^19
07FFFF 00001
77E002 FFFFF
012345 6DCBB
7EBCBC 92345
00000005
0 000 000 00   // corner run
1 000 000 00   // random run at zero bases
1 1A0 2C4 00   // shifted bases
1 100 080 0C   // zeroize sampled on cycle 12
1 100 080 00   // clean run after zeroize

// ==== sim.f ====
source/sigencode_z_pkg.sv
source/coeff_mem.sv
source/sigencode_z_ctrl.sv
source/sigencode_z_encoder.sv
source/sigencode_z_top.sv
verif/sigencode_z_tb.sv
